// File: vlog.f
rtl/ifu_pkg.sv
rtl/fetch_q_if.sv
rtl/ifu_fetch_ctl.sv
rtl/fetch_buf.sv
rtl/ifu_aligner.sv
rtl/ifu_top.sv
bench/tb_clk_gen.sv
bench/ifu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the IFU testbench with Verilator, runs it and checks the result

set -u
cd "$(dirname "$0")" || exit 1

# Build the simulation binary from the file list
verilator --binary --timing -Wno-fatal --top-module ifu_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Run and keep the output in memory only
sim_out=$(./obj_dir/Vifu_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASSED$"; then
   exit 0
else
   echo "Pass message not found in simulation output"
   exit 1
fi

// File: bench/ifu_tb.sv
/*
 * Instruction fetch unit testbench
 * Random instruction memory with one cycle read latency, a reference
 * model of the halfword stream and a compare process on every
 * accepted instruction. Covers streaming, back-pressure, redirects,
 * halting flushes and access faults.
 */

`timescale 1ns/1ps

module ifu_tb;

   logic                  clk;
   logic                  rst_n;
   logic                  dec_i0_decode_d;
   logic                  exu_flush_final;
   ifu_pkg::pc_t          exu_flush_path_final;
   logic                  dec_tlu_flush_noredir_wb;
   logic                  imem_rd_en;
   logic [31:2]           imem_addr;
   ifu_pkg::word_t        imem_rd_data;
   logic                  ifu_i0_valid;
   ifu_pkg::word_t        ifu_i0_instr;
   ifu_pkg::pc_t          ifu_i0_pc;
   logic                  ifu_i0_pc4;
   logic                  ifu_i0_icaf;

   ifu_pkg::word_t        mem [ifu_pkg::IMEM_WORDS];  // Instruction memory image
   logic [31:0]           lfsr_q;                     // Galois LFSR state
   ifu_pkg::pc_t          exp_pc;                     // Next expected pc
   logic                  exp_stop;                   // No instruction expected
   int                    acc_cnt;                    // Accepted and checked
   ifu_pkg::word_t        exp_instr;
   logic                  exp_pc4;
   logic                  exp_fault;

   tb_clk_gen clk_gen (.clk(clk));

   ifu_top uut (
      .clk                      (clk),
      .rst_n                    (rst_n),
      .dec_i0_decode_d          (dec_i0_decode_d),
      .exu_flush_final          (exu_flush_final),
      .exu_flush_path_final     (exu_flush_path_final),
      .dec_tlu_flush_noredir_wb (dec_tlu_flush_noredir_wb),
      .imem_rd_en               (imem_rd_en),
      .imem_addr                (imem_addr),
      .imem_rd_data             (imem_rd_data),
      .ifu_i0_valid             (ifu_i0_valid),
      .ifu_i0_instr             (ifu_i0_instr),
      .ifu_i0_pc                (ifu_i0_pc),
      .ifu_i0_pc4               (ifu_i0_pc4),
      .ifu_i0_icaf              (ifu_i0_icaf)
   );

   //**********************************************************
   // Failure reporting and value check
   //**********************************************************
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at first failure");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("** Error at %0d ns: %s got %h expected %h",
                             $time, what, got, exp));
      end
   endtask

   //**********************************************************
   // Random source and memory image
   //**********************************************************
   function automatic logic rand_bit();
      logic b;
      b = lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);  // x^32+x^22+x^2+x+1
      return b;
   endfunction

   task automatic fill_memory();
      for (int i = 0; i < ifu_pkg::IMEM_WORDS; i++) begin
         for (int b = 0; b < 32; b++) begin
            mem[i][b] = rand_bit();               // One step per bit
         end
      end
   endtask

   // Data one clock after the read strobe
   always @(posedge clk) begin
      if (imem_rd_en) begin
         if (!rst_n) begin
            abort_run("Memory read issued during reset");
         end
         if ((imem_addr - ifu_pkg::IMEM_BASE[31:2]) >= ifu_pkg::IMEM_WORDS) begin
            abort_run($sformatf("Memory read issued outside region, word address %h",
                                imem_addr));
         end
         imem_rd_data <= mem[int'(imem_addr - ifu_pkg::IMEM_BASE[31:2])];
      end
   end

   //**********************************************************
   // Reference model
   //**********************************************************
   function automatic logic in_imem(input ifu_pkg::pc_t pc);
      logic [31:2] wa;
      wa = pc[31:2];
      return (wa >= ifu_pkg::IMEM_BASE[31:2]) &&
             ((wa - ifu_pkg::IMEM_BASE[31:2]) < ifu_pkg::IMEM_WORDS);
   endfunction

   function automatic logic [15:0] halfword(input ifu_pkg::pc_t pc);
      ifu_pkg::word_t w;
      w = mem[int'(pc[31:2] - ifu_pkg::IMEM_BASE[31:2])];
      return pc[1] ? w[31:16] : w[15:0];
   endfunction

   // Expected instruction, length and fault at one pc
   function automatic void ref_instr(input ifu_pkg::pc_t pc, output ifu_pkg::word_t instr,
                                     output logic pc4, output logic fault);
      logic [15:0]   lo_hw;
      ifu_pkg::pc_t  hi_pc;
      instr = '0;
      pc4   = 1'b0;
      fault = 1'b0;
      hi_pc = pc + 31'd1;
      if (!in_imem(pc)) begin
         fault = 1'b1;                            // First half unreadable
      end else begin
         lo_hw = halfword(pc);
         if (lo_hw[1:0] != 2'b11) begin
            instr = {16'b0, lo_hw};               // Compressed
         end else begin
            pc4 = 1'b1;
            if (!in_imem(hi_pc)) begin
               fault = 1'b1;                      // Second half unreadable
            end else begin
               instr = {halfword(hi_pc), lo_hw};
            end
         end
      end
   endfunction

   //**********************************************************
   // Compare process
   //**********************************************************
   always @(posedge clk) begin
      if (rst_n) begin
         if (exu_flush_final) begin
            exp_pc   = exu_flush_path_final;      // Stream restarts here
            exp_stop = dec_tlu_flush_noredir_wb;
         end else if (ifu_i0_valid && dec_i0_decode_d) begin
            if (exp_stop) begin
               abort_run($sformatf("Instruction accepted at %0d ns while fetch was stopped",
                                   $time));
            end
            ref_instr(exp_pc, exp_instr, exp_pc4, exp_fault);
            check_value("ifu_i0_pc", {1'b0, ifu_i0_pc}, {1'b0, exp_pc});
            check_value("ifu_i0_instr", ifu_i0_instr, exp_instr);
            check_value("ifu_i0_pc4", {31'b0, ifu_i0_pc4}, {31'b0, exp_pc4});
            check_value("ifu_i0_icaf", {31'b0, ifu_i0_icaf}, {31'b0, exp_fault});
            exp_stop = exp_fault;                 // Fault halts the stream
            exp_pc   = exp_pc + (exp_pc4 ? 31'd2 : 31'd1);
            acc_cnt  = acc_cnt + 1;
         end
      end
   end

   //**********************************************************
   // Stimulus helpers
   //**********************************************************
   task automatic run_accepts(input int n, input logic random_ready);
      int target;
      int cycles;
      target = acc_cnt + n;
      cycles = 0;
      while (acc_cnt < target) begin
         if (cycles == n * 20) begin
            abort_run($sformatf("Timeout waiting for %0d instructions, %0d seen",
                                n, n - (target - acc_cnt)));
         end
         @(negedge clk);
         dec_i0_decode_d = random_ready ? rand_bit() : 1'b1;
         cycles++;
      end
   endtask

   task automatic flush_to(input logic [31:0] byte_addr, input logic noredir);
      @(negedge clk);
      exu_flush_final          = 1'b1;            // One cycle strobe
      exu_flush_path_final     = byte_addr[31:1];
      dec_tlu_flush_noredir_wb = noredir;
      @(negedge clk);
      exu_flush_final          = 1'b0;
      dec_tlu_flush_noredir_wb = 1'b0;
   endtask

   task automatic wait_stop();
      int cycles;
      cycles = 0;
      while (!exp_stop) begin
         if (cycles == 200) begin
            abort_run("Timeout waiting for the access fault instruction");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic idle_check(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         check_value("ifu_i0_valid while stopped", {31'b0, ifu_i0_valid}, 32'd0);
      end
   endtask

   //**********************************************************
   // Scenarios
   //**********************************************************
   initial begin
      lfsr_q                   = 32'h199c_1aac;
      rst_n                    = 1'b0;
      dec_i0_decode_d          = 1'b0;
      exu_flush_final          = 1'b0;
      exu_flush_path_final     = '0;
      dec_tlu_flush_noredir_wb = 1'b0;
      imem_rd_data             = '0;
      exp_pc                   = ifu_pkg::RESET_PC[31:1];
      exp_stop                 = 1'b0;
      acc_cnt                  = 0;
      fill_memory();
      repeat (8) @(posedge clk);                  // Reset held 8 cycles
      @(negedge clk);
      rst_n = 1'b1;

      run_accepts(200, 1'b0);                     // Sequential stream
      run_accepts(200, 1'b1);                     // Random decode stalls
      dec_i0_decode_d = 1'b1;

      flush_to(32'h0000_0106, 1'b0);              // Upper halfword target
      run_accepts(100, 1'b0);

      flush_to(32'h0000_0400, 1'b1);              // Halt without redirect
      idle_check(50);
      flush_to(32'h0000_0a02, 1'b0);              // Resume
      run_accepts(60, 1'b0);

      flush_to(32'h0000_1006, 1'b0);              // Outside region
      wait_stop();
      idle_check(50);

      flush_to(32'h0000_0ffe, 1'b0);              // Last halfword so the stream runs off the end
      wait_stop();
      idle_check(50);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: bench/tb_clk_gen.sv
/*
 * Testbench clock generator
 * Free running clock, 100 ns period
 */

`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk
);

   initial begin
      clk = 1'b0;                                 // Known level at time zero
      forever begin
         #50 clk = ~clk;                          // Half period
      end
   end

endmodule

// File: rtl/ifu_top.sv
/*
 * Instruction fetch unit top level
 * Fetch control, fetch buffer and aligner joined by the fetch
 * queue interface, plain ports toward memory, decode and flush
 */

`timescale 1ns/1ps

module ifu_top (
   input  logic                  clk,
   input  logic                  rst_n,

   // Decode handshake
   input  logic                  dec_i0_decode_d,          // Decode accepts i0

   // Flush
   input  logic                  exu_flush_final,          // Flush strobe
   input  ifu_pkg::pc_t          exu_flush_path_final,     // Restart address
   input  logic                  dec_tlu_flush_noredir_wb, // Halt fetch

   // Instruction memory
   output logic                  imem_rd_en,
   output logic [31:2]           imem_addr,
   input  ifu_pkg::word_t        imem_rd_data,

   // To decode
   output logic                  ifu_i0_valid,
   output ifu_pkg::word_t        ifu_i0_instr,
   output ifu_pkg::pc_t          ifu_i0_pc,
   output logic                  ifu_i0_pc4,
   output logic                  ifu_i0_icaf
);

   fetch_q_if fq ();                              // Packet queue link

   //**********************************************************
   // Fetch, buffer, align
   //**********************************************************
   ifu_fetch_ctl ifc (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (exu_flush_final),
      .flush_path    (exu_flush_path_final),
      .flush_noredir (dec_tlu_flush_noredir_wb),
      .imem_rd_en    (imem_rd_en),
      .imem_addr     (imem_addr),
      .imem_rd_data  (imem_rd_data),
      .q             (fq.producer)
   );

   fetch_buf fb (
      .clk   (clk),
      .rst_n (rst_n),
      .flush (exu_flush_final),
      .q     (fq.queue)
   );

   ifu_aligner aln (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (exu_flush_final),
      .q        (fq.consumer),
      .decode_d (dec_i0_decode_d),
      .i0_valid (ifu_i0_valid),
      .i0_instr (ifu_i0_instr),
      .i0_pc    (ifu_i0_pc),
      .i0_pc4   (ifu_i0_pc4),
      .i0_icaf  (ifu_i0_icaf)
   );

endmodule

// File: rtl/ifu_aligner.sv
/*
 * Instruction aligner
 * Cuts fetch packets into 16 and 32 bit instructions, joins words
 * for instructions that span two packets and holds the result until
 * decode accepts it. Fault packets turn into access fault entries.
 */

`timescale 1ns/1ps

module ifu_aligner (
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  flush,          // Drops held state
   fetch_q_if.consumer           q,

   input  logic                  decode_d,       // Decode takes instruction
   output logic                  i0_valid,
   output ifu_pkg::word_t        i0_instr,       // Zero extended when 16 bit
   output ifu_pkg::pc_t          i0_pc,
   output logic                  i0_pc4,         // 32 bit instruction
   output logic                  i0_icaf         // Access fault
);

   logic [15:0]           hw_q;                  // Leftover halfword
   ifu_pkg::pc_t          hw_pc_q;               // Its pc
   logic                  hw_v_q;
   ifu_pkg::fetch_pkt_t   pkt;
   logic                  pkt_v;                 // Packet available
   logic [15:0]           pkt_lo;
   logic [15:0]           pkt_hi;
   logic                  load_ok;               // Output free or taken
   logic                  emit;                  // Instruction formed
   logic                  take;                  // Packet data needed
   logic                  hw_load;               // Upper half kept
   logic                  nxt_hw_v;
   ifu_pkg::word_t        nxt_instr;
   ifu_pkg::pc_t          nxt_pc;
   logic                  nxt_pc4;
   logic                  nxt_icaf;

   assign pkt     = q.pop_pkt;
   assign pkt_v   = ~q.empty;
   assign pkt_lo  = pkt.data[15:0];
   assign pkt_hi  = pkt.data[31:16];
   assign load_ok = ~i0_valid | decode_d;

   //**********************************************************
   // Next instruction, one per cycle
   //**********************************************************
   always_comb begin
      emit      = 1'b0;
      take      = 1'b0;
      hw_load   = 1'b0;
      nxt_hw_v  = hw_v_q;
      nxt_instr = '0;
      nxt_pc    = hw_pc_q;
      nxt_pc4   = 1'b0;
      nxt_icaf  = 1'b0;
      if (hw_v_q) begin
         if (hw_q[1:0] != 2'b11) begin            // 16 bit from leftover
            emit      = 1'b1;
            nxt_instr = {16'b0, hw_q};
            nxt_hw_v  = 1'b0;
         end else if (pkt_v) begin                // 32 bit spanning two words
            emit    = 1'b1;
            take    = 1'b1;
            nxt_pc4 = 1'b1;
            if (pkt.fault) begin
               nxt_icaf = 1'b1;                   // Second half unread
               nxt_hw_v = 1'b0;
            end else begin
               nxt_instr = {pkt_lo, hw_q};
               hw_load   = 1'b1;                  // Upper half stays behind
            end
         end
      end else if (pkt_v) begin
         take   = 1'b1;
         nxt_pc = {pkt.word_addr, pkt.start_hi};
         if (pkt.fault) begin
            emit     = 1'b1;
            nxt_icaf = 1'b1;
         end else if (pkt.start_hi) begin         // Lower half skipped
            if (pkt_hi[1:0] == 2'b11) begin
               hw_load  = 1'b1;                   // Wait for next word
               nxt_hw_v = 1'b1;
            end else begin
               emit      = 1'b1;
               nxt_instr = {16'b0, pkt_hi};
            end
         end else if (pkt_lo[1:0] == 2'b11) begin // Whole word
            emit      = 1'b1;
            nxt_instr = pkt.data;
            nxt_pc4   = 1'b1;
         end else begin
            emit      = 1'b1;
            nxt_instr = {16'b0, pkt_lo};
            hw_load   = 1'b1;
            nxt_hw_v  = 1'b1;
         end
      end
   end

   assign q.pop = load_ok & take;                 // take implies not empty

   //**********************************************************
   // Leftover and presented instruction
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hw_v_q   <= 1'b0;
         i0_valid <= 1'b0;
      end else if (flush) begin
         hw_v_q   <= 1'b0;
         i0_valid <= 1'b0;
      end else if (load_ok) begin
         hw_v_q   <= nxt_hw_v;
         i0_valid <= emit;
      end
   end

   always_ff @(posedge clk) begin
      if (load_ok && hw_load) begin
         hw_q    <= pkt_hi;
         hw_pc_q <= {pkt.word_addr, 1'b1};        // Upper half of that word
      end
      if (load_ok && emit) begin
         i0_instr <= nxt_instr;
         i0_pc    <= nxt_pc;
         i0_pc4   <= nxt_pc4;
         i0_icaf  <= nxt_icaf;
      end
   end

endmodule

// File: rtl/fetch_buf.sv
/*
 * Fetch buffer
 * Circular FIFO of fetch packets between fetch control and the
 * aligner. Reports free entries and empty, emptied by a flush.
 */

`timescale 1ns/1ps

module fetch_buf (
   input  logic        clk,
   input  logic        rst_n,

   input  logic        flush,                    // Drops all entries
   fetch_q_if.queue    q
);

   ifu_pkg::fetch_pkt_t                    mem [ifu_pkg::FB_DEPTH];  // Entry storage
   logic [$clog2(ifu_pkg::FB_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(ifu_pkg::FB_DEPTH)-1:0]   rd_ptr;
   logic [ifu_pkg::FB_CNT_W-1:0]           count;        // Entries held
   logic                                   push_ok;      // Push not killed by flush

   assign push_ok = q.push & ~flush;

   //**********************************************************
   // Status toward both sides
   //**********************************************************
   assign q.free_cnt = ifu_pkg::FB_DEPTH - count;
   assign q.empty    = (count == '0);
   assign q.pop_pkt  = mem[rd_ptr];              // Oldest entry always shown

   //**********************************************************
   // Pointers and occupancy
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;                            // Same edge clear
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;              // Power of two depth wraps
         end
         if (q.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_ok, q.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;              // Both or neither
         endcase
      end
   end

   // Entry write
   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= q.push_pkt;
      end
   end

endmodule

// File: rtl/ifu_fetch_ctl.sv
/*
 * Fetch controller
 * Steps the word fetch address, issues reads to the instruction
 * memory and pushes one packet per word into the fetch buffer.
 * Out of region fetches become fault packets and halt fetch,
 * flushes redirect or halt the stream.
 */

`timescale 1ns/1ps

module ifu_fetch_ctl (
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  flush,          // Flush strobe
   input  ifu_pkg::pc_t          flush_path,     // Restart halfword address
   input  logic                  flush_noredir,  // Halt instead of restart

   output logic                  imem_rd_en,     // Read strobe
   output logic [31:2]           imem_addr,      // Word address
   input  ifu_pkg::word_t        imem_rd_data,   // One clock after rd_en

   fetch_q_if.producer           q
);

   logic [31:2]                    fetch_addr;   // Next word to fetch
   logic                           start_hi;     // First word after redirect
   logic                           stopped;      // Halted until next flush
   logic                           pend_q;       // Request in flight
   logic [31:2]                    pend_addr;    // Address of that request
   logic                           pend_start_hi;
   logic                           pend_fault;
   logic [31:2]                    word_off;     // Offset into region
   logic                           in_region;
   logic                           req;          // Request this cycle
   logic [ifu_pkg::FB_CNT_W-1:0]   inflight_cnt;

   //**********************************************************
   // Request decision
   //**********************************************************
   assign word_off  = fetch_addr - ifu_pkg::IMEM_BASE[31:2];
   assign in_region = (fetch_addr >= ifu_pkg::IMEM_BASE[31:2]) &&
                      (word_off < ifu_pkg::IMEM_WORDS);

   assign inflight_cnt = {{(ifu_pkg::FB_CNT_W-1){1'b0}}, pend_q};

   // Room needed for the in-flight word too
   assign req = rst_n & ~stopped & ~flush & (q.free_cnt > inflight_cnt);

   assign imem_rd_en = req & in_region;          // Faults never reach memory
   assign imem_addr  = fetch_addr;

   //**********************************************************
   // Fetch address and control flags
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch_addr <= ifu_pkg::RESET_PC[31:2];
         start_hi   <= ifu_pkg::RESET_PC[1];
         stopped    <= 1'b0;
         pend_q     <= 1'b0;
      end else if (flush) begin
         fetch_addr <= flush_path[31:2];          // Redirect target word
         start_hi   <= flush_path[1];             // Halfword aligned target
         stopped    <= flush_noredir;             // Halt when no redirect
         pend_q     <= 1'b0;                      // Nothing issued in flush cycle
      end else begin
         pend_q <= req;
         if (req) begin
            fetch_addr <= fetch_addr + 30'd1;
            start_hi   <= 1'b0;
            stopped    <= ~in_region;             // Fault halts fetch
         end
      end
   end

   // Request details for the push one cycle later
   always_ff @(posedge clk) begin
      if (req) begin
         pend_addr     <= fetch_addr;
         pend_start_hi <= start_hi;
         pend_fault    <= ~in_region;
      end
   end

   //**********************************************************
   // Packet push where memory data lands
   //**********************************************************
   assign q.push              = pend_q;
   assign q.push_pkt.word_addr = pend_addr;
   assign q.push_pkt.data     = pend_fault ? '0 : imem_rd_data;  // Nothing read on fault
   assign q.push_pkt.start_hi = pend_start_hi;
   assign q.push_pkt.fault    = pend_fault;

endmodule

// File: rtl/fetch_q_if.sv
/*
 * Fetch packet queue interface
 * Push side from fetch control, pop side to the aligner,
 * the fetch buffer sits in the middle
 */

`timescale 1ns/1ps

interface fetch_q_if;

   logic                          push;         // One cycle strobe
   ifu_pkg::fetch_pkt_t           push_pkt;     // Packet being pushed
   logic [ifu_pkg::FB_CNT_W-1:0]  free_cnt;     // Empty entries
   logic                          pop;          // One cycle strobe
   ifu_pkg::fetch_pkt_t           pop_pkt;      // Oldest entry
   logic                          empty;        // No entry held

   // Fetch control
   modport producer (output push, output push_pkt, input free_cnt);

   // Fetch buffer
   modport queue (input push, input push_pkt, output free_cnt,
                  input pop, output pop_pkt, output empty);

   // Aligner
   modport consumer (output pop, input pop_pkt, input empty);

endinterface

// File: rtl/ifu_pkg.sv
/*
 * Instruction fetch unit shared definitions
 * Address and word types, instruction memory region, fetch buffer
 * sizing and the fetch packet passed from fetch control to the aligner
 */

package ifu_pkg;

   //**********************************************************
   // Address and data types
   //**********************************************************
   localparam int ADDR_W = 32;                  // Byte address width

   typedef logic [31:1] pc_t;                   // Halfword address
   typedef logic [31:0] word_t;                 // Instruction memory word

   //**********************************************************
   // Memory map
   //**********************************************************
   localparam logic [ADDR_W-1:0] RESET_PC  = 32'h0000_0000;  // First fetch after reset
   localparam logic [ADDR_W-1:0] IMEM_BASE = 32'h0000_0000;  // Region base, byte address
   localparam logic [ADDR_W-1:2] IMEM_WORDS = 30'd1024;      // Region size in words, 4 KiB

   //**********************************************************
   // Fetch buffer
   //**********************************************************
   localparam int FB_CNT_W = 3;                             // Free slot count width
   localparam logic [FB_CNT_W-1:0] FB_DEPTH = 3'd4;         // Entries

   // One fetched word on its way to the aligner
   typedef struct packed {
      logic [ADDR_W-1:2] word_addr;             // Word address of data
      word_t             data;                  // Zero when faulted
      logic              start_hi;              // Stream starts at upper half
      logic              fault;                 // Outside region, not read
   } fetch_pkt_t;

endpackage
